/* compile.f */
+incdir+tests
logic/cpuIsaPkg.sv
logic/regBusPkg.sv
logic/apbInstrPort.sv
logic/phaseSequencer.sv
logic/opxDecoder.sv
logic/registerSequencer.sv
logic/registerFile.sv
logic/regStageTop.sv
tests/regStageTb.sv

/* logic/apbInstrPort.sv */
`timescale 1ns/1ps

module apbInstrPort #(
	parameter int DATA_WIDTH = 16
) (
	input  logic                    CLK,
	input  logic                    RESET,
	input  regBusPkg::apbReq        req,
	output regBusPkg::apbRsp        rsp,
	input  cpuIsaPkg::cpuPhase      phase,
	output logic                    instrValid,
	output cpuIsaPkg::instrWord     instr,
	output logic [2:0]              rdIndex,
	input  logic [DATA_WIDTH-1:0]   rdData
);
	import cpuIsaPkg::*;
	import regBusPkg::*;

	localparam logic [APB_ADDR_W-1:0] INSTR_ADDR = 8'h00;
	localparam logic [3:0]            REG_PAGE   = 4'h1;   // 0x10..0x1e

	logic     access;      // access phase of a transfer
	logic     hitInstr;    // instruction write address
	logic     hitReg;      // even register read address
	logic     busy;        // an instruction is in flight

	// ##########################################################################
	// address decode
	// ##########################################################################

	assign access   = req.psel & req.penable;
	assign hitInstr = (req.paddr == INSTR_ADDR) & req.pwrite;
	assign hitReg   = (req.paddr[7:4] == REG_PAGE) & !req.paddr[0] & !req.pwrite;
	assign busy     = (phase != IDLE);
	assign rdIndex  = req.paddr[3:1];   // 2 byte stride

	always_comb begin
		rsp.pready  = !(hitInstr & busy);             // only instruction writes stall
		rsp.pslverr = access & !hitInstr & !hitReg;   // reads of 0x00 land here too
		rsp.prdata  = hitReg ? APB_DATA_W'(rdData) : '0;
	end

	// ##########################################################################
	// instruction accept
	// ##########################################################################

	// one cycle, a completing transfer never repeats
	assign instrValid = access & hitInstr & rsp.pready;

	// live word, registered by the decoder on the accept edge
	assign instr = instrWord'(req.pwdata);

	// accept only from IDLE, and the sequencer must leave IDLE on that edge
	assert property (@(posedge CLK) disable iff (RESET)
		instrValid |-> (phase == IDLE) ##1 (phase inside {FETCH, STOPPED}))
		else $error("instruction accepted outside IDLE or phase did not start");

endmodule

/* logic/cpuIsaPkg.sv */
package cpuIsaPkg;

	// ##########################################################################
	// register cycle codes, bits 15..12 of every instruction
	// ##########################################################################

	typedef enum logic [3:0] {
		NONE    = 4'd0,     // no register traffic
		RDA_RDB = 4'd1,     // read A and B
		LDA_RDB = 4'd2,     // A <= B
		LDA_UPB = 4'd3,     // A <= B, B steps down
		RDA_UPB = 4'd4,     // read A, B steps down
		LDA_IMM = 4'd5,     // A <= zero extended immediate
		RDA_IMM = 4'd6,     // read A alongside the immediate
		UPA_RDB = 4'd7,     // A <= A + B
		UPA_IMM = 4'd8,     // A <= A + immediate
		RDB     = 4'd9      // read B only
	} regSeqX;              // codes 10..15 decode as NONE

	// ##########################################################################
	// instruction word, one 16 bit word seen two ways
	// ##########################################################################

	// common top byte of both layouts
	typedef struct packed {
		logic [3:0] code;   // raw register cycle code
		logic       byteX;  // byte lane operation
		logic [2:0] regA;   // register A index
	} instrHead;

	// register form, B index follows the head
	typedef struct packed {
		instrHead   head;
		logic [2:0] regB;
		logic [4:0] spare;  // unused low bits
	} regLayout;

	// immediate form, the low byte is data
	typedef struct packed {
		instrHead   head;
		logic [7:0] imm;
	} immLayout;

	typedef union packed {
		regLayout regView;
		immLayout immView;
	} instrWord;

	// ##########################################################################
	// instruction phases
	// ##########################################################################

	typedef enum logic [2:0] {
		IDLE      = 3'd0,   // waiting for the host
		STOPPED   = 3'd1,   // accepted but held by halt
		FETCH     = 3'd2,
		DECODE    = 3'd3,
		EXECUTE   = 3'd4,   // read enables load at the end
		COMMIT    = 3'd5,   // operands captured, write enables load
		WRITEBACK = 3'd6    // register writes land at the end
	} cpuPhase;

endpackage

/* logic/opxDecoder.sv */
`timescale 1ns/1ps

module opxDecoder #(
	parameter int REG_COUNT = 8
) (
	input  logic                CLK,
	input  logic                RESET,
	input  logic                instrValid,
	input  cpuIsaPkg::instrWord instr,
	output regBusPkg::decodedOp op
);
	import cpuIsaPkg::*;
	import regBusPkg::*;

	regSeqX   rawSeq;   // code as written, may be out of table
	logic     isImm;    // immediate layout in use
	decodedOp nxtOp;

	// code sits in the shared head, either view gives the same bits
	assign rawSeq = regSeqX'(instr.regView.head.code);
	assign isImm  = rawSeq inside {LDA_IMM, RDA_IMM, UPA_IMM};

	always_comb begin
		nxtOp = '0;

		// ##########################################################################
		// register cycle code
		// ##########################################################################
		case (rawSeq)
			NONE, RDA_RDB, LDA_RDB, LDA_UPB, RDA_UPB,
			LDA_IMM, RDA_IMM, UPA_RDB, UPA_IMM, RDB: begin
				nxtOp.seq = rawSeq;
			end
			default: begin
				nxtOp.seq = NONE;   // codes past RDB do nothing
			end
		endcase

		// ##########################################################################
		// operand fields, view picked by the code
		// ##########################################################################
		nxtOp.byteX = instr.regView.head.byteX;                   // head is common to both views
		nxtOp.regA  = 3'(instr.regView.head.regA % REG_COUNT);
		if (isImm) begin
			nxtOp.imm  = instr.immView.imm;   // regB stays zero
		end else begin
			nxtOp.regB = 3'(instr.regView.regB % REG_COUNT);
		end
	end

	// held for the whole instruction, reloaded only on accept
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			op <= '0;   // seq reads as NONE
		end else if (instrValid) begin
			op <= nxtOp;
		end
	end

endmodule

/* logic/phaseSequencer.sv */
`timescale 1ns/1ps

module phaseSequencer (
	input  logic               CLK,
	input  logic               RESET,
	input  logic               instrValid,
	input  logic               halt,
	output cpuIsaPkg::cpuPhase phase
);
	import cpuIsaPkg::*;

	localparam int PHASES = WRITEBACK + 1;

	logic [PHASES-1:0] hot;      // one bit per phase, indexed by encoding
	logic [PHASES-1:0] hotNxt;

	// legal successor table
	function automatic logic legalStep(cpuPhase prev, cpuPhase cur);
		case (prev)
			IDLE:      legalStep = cur inside {IDLE, STOPPED, FETCH};
			STOPPED:   legalStep = cur inside {STOPPED, FETCH};
			FETCH:     legalStep = (cur == DECODE);
			DECODE:    legalStep = (cur == EXECUTE);
			EXECUTE:   legalStep = (cur == COMMIT);
			COMMIT:    legalStep = (cur == WRITEBACK);
			WRITEBACK: legalStep = (cur == IDLE);
			default:   legalStep = 1'b0;
		endcase
	endfunction

	always_comb begin
		hotNxt            = '0;
		hotNxt[IDLE]      = hot[WRITEBACK] | (hot[IDLE] & !instrValid);
		hotNxt[STOPPED]   = (hot[IDLE] & instrValid & halt) | (hot[STOPPED] & halt);
		hotNxt[FETCH]     = (hot[IDLE] & instrValid & !halt) | (hot[STOPPED] & !halt);
		hotNxt[DECODE]    = hot[FETCH];     // fixed walk from here on
		hotNxt[EXECUTE]   = hot[DECODE];
		hotNxt[COMMIT]    = hot[EXECUTE];
		hotNxt[WRITEBACK] = hot[COMMIT];
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			hot <= PHASES'(1);   // IDLE bit
		end else begin
			hot <= hotNxt;
		end
	end

	// encode back to the shared phase type
	always_comb begin
		phase = IDLE;
		for (int i = 0; i < PHASES; i++) begin
			if (hot[i]) begin
				phase = cpuPhase'(i);
			end
		end
	end

	assert property (@(posedge CLK) disable iff (RESET)
		$onehot(hot) && legalStep($past(phase), phase))
		else $error("phase left its legal successor");

endmodule

/* logic/regBusPkg.sv */
package regBusPkg;

	// ##########################################################################
	// APB slave side
	// ##########################################################################

	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 16;

	// host to slave
	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [APB_DATA_W-1:0] pwdata;
	} apbReq;

	// slave to host
	typedef struct packed {
		logic                  pready;
		logic                  pslverr;
		logic [APB_DATA_W-1:0] prdata;
	} apbRsp;

	// ##########################################################################
	// internal register traffic
	// ##########################################################################

	// strobes from the register sequencer
	typedef struct packed {
		logic regAEn;
		logic regAWen;
		logic regBEn;
		logic regBWen;
	} regCtrl;

	// decoded instruction, indices sized for 8 registers
	typedef struct packed {
		cpuIsaPkg::regSeqX seq;
		logic              byteX;
		logic [2:0]        regA;
		logic [2:0]        regB;   // zero for immediate forms
		logic [7:0]        imm;    // zero for register forms
	} decodedOp;

endpackage

/* logic/regStageTop.sv */
`timescale 1ns/1ps

module regStageTop #(
	parameter int DATA_WIDTH = 16,
	parameter int REG_COUNT  = 8    // 8 at most, indices are 3 bits
) (
	input  logic             CLK,
	input  logic             RESET,
	input  regBusPkg::apbReq apbIn,
	output regBusPkg::apbRsp apbOut,
	input  logic             halt
);
	import cpuIsaPkg::*;
	import regBusPkg::*;

	logic                  instrValid;   // accept pulse
	instrWord              instr;
	cpuPhase               phase;
	decodedOp              op;
	regCtrl                ctrl;
	logic [2:0]            rdIndex;      // host read path
	logic [DATA_WIDTH-1:0] rdData;

	// ##########################################################################
	// host side
	// ##########################################################################

	apbInstrPort #(.DATA_WIDTH(DATA_WIDTH)) port (
		.CLK        (CLK),
		.RESET      (RESET),
		.req        (apbIn),
		.rsp        (apbOut),
		.phase      (phase),
		.instrValid (instrValid),
		.instr      (instr),
		.rdIndex    (rdIndex),
		.rdData     (rdData)
	);

	// ##########################################################################
	// sequencing and decode
	// ##########################################################################

	phaseSequencer phaseSeq (
		.CLK        (CLK),
		.RESET      (RESET),
		.instrValid (instrValid),
		.halt       (halt),
		.phase      (phase)
	);

	opxDecoder #(.REG_COUNT(REG_COUNT)) decoder (
		.CLK        (CLK),
		.RESET      (RESET),
		.instrValid (instrValid),
		.instr      (instr),
		.op         (op)
	);

	registerSequencer regSeq (
		.CLK   (CLK),
		.RESET (RESET),
		.phase (phase),
		.seq   (op.seq),
		.ctrl  (ctrl)
	);

	registerFile #(.DATA_WIDTH(DATA_WIDTH), .REG_COUNT(REG_COUNT)) regFile (
		.CLK     (CLK),
		.RESET   (RESET),
		.ctrl    (ctrl),
		.op      (op),
		.rdIndex (rdIndex),
		.rdData  (rdData)
	);

endmodule

/* logic/registerFile.sv */
`timescale 1ns/1ps

module registerFile #(
	parameter int DATA_WIDTH = 16,
	parameter int REG_COUNT  = 8
) (
	input  logic                  CLK,
	input  logic                  RESET,
	input  regBusPkg::regCtrl     ctrl,
	input  regBusPkg::decodedOp   op,
	input  logic [2:0]            rdIndex,
	output logic [DATA_WIDTH-1:0] rdData
);
	import cpuIsaPkg::*;
	import regBusPkg::*;

	logic [DATA_WIDTH-1:0] regs [REG_COUNT];
	logic [DATA_WIDTH-1:0] opA;     // A operand captured at end of COMMIT
	logic [DATA_WIDTH-1:0] opB;
	logic [DATA_WIDTH-1:0] immX;    // zero extended immediate
	logic [DATA_WIDTH-1:0] stepB;   // stack step size
	logic [DATA_WIDTH-1:0] newA;
	logic [DATA_WIDTH-1:0] newB;
	regCtrl                ctrlQ;   // strobes one cycle late, for edge detect
	logic                  captureA;
	logic                  captureB;
	logic                  writeA;
	logic                  writeB;

	// strobes linger into IDLE, so act on the first cycle only
	assign captureA = ctrl.regAEn & !ctrlQ.regAEn;
	assign captureB = ctrl.regBEn & !ctrlQ.regBEn;
	assign writeA   = ctrl.regAWen & !ctrlQ.regAWen;
	assign writeB   = ctrl.regBWen & !ctrlQ.regBWen;

	// ##########################################################################
	// write values
	// ##########################################################################

	assign immX  = DATA_WIDTH'(op.imm);
	assign stepB = op.byteX ? DATA_WIDTH'(1) : DATA_WIDTH'(2);

	always_comb begin
		case (op.seq)
			LDA_RDB, LDA_UPB: newA = opB;
			LDA_IMM:          newA = immX;
			UPA_RDB:          newA = opA + opB;
			UPA_IMM:          newA = opA + immX;
			default:          newA = opA;   // no A write for the rest
		endcase
		if (op.byteX) begin
			newA = {opA[DATA_WIDTH-1:8], newA[7:0]};   // low lane only
		end
		newB = opB - stepB;                           // only UPB forms write B
	end

	// ##########################################################################
	// array and operands
	// ##########################################################################

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			ctrlQ <= '0;
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			ctrlQ <= ctrl;
			if (writeA) begin
				regs[op.regA] <= newA;
			end
			if (writeB) begin
				regs[op.regB] <= newB;   // last assignment, B wins a clash
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (captureA) begin
			opA <= regs[op.regA];
		end
		if (captureB) begin
			opB <= regs[op.regB];
		end
	end

	// host read port, indices past the array read zero
	assign rdData = (rdIndex < REG_COUNT) ? regs[rdIndex] : '0;

endmodule

/* logic/registerSequencer.sv */
`timescale 1ns/1ps

module registerSequencer (
	input  logic               CLK,
	input  logic               RESET,
	input  cpuIsaPkg::cpuPhase phase,
	input  cpuIsaPkg::regSeqX  seq,
	output regBusPkg::regCtrl  ctrl
);
	import cpuIsaPkg::*;
	import regBusPkg::*;

	regCtrl tableCtrl;   // strobes wanted by the current code

	// ##########################################################################
	// code table
	// ##########################################################################

	// columns are regAEn, regAWen, regBEn, regBWen
	always_comb begin
		case (seq)
			RDA_RDB: tableCtrl = '{1'b1, 1'b0, 1'b1, 1'b0};
			LDA_RDB: tableCtrl = '{1'b1, 1'b1, 1'b1, 1'b0};
			LDA_UPB: tableCtrl = '{1'b1, 1'b1, 1'b1, 1'b1};
			RDA_UPB: tableCtrl = '{1'b1, 1'b0, 1'b1, 1'b1};
			LDA_IMM: tableCtrl = '{1'b1, 1'b1, 1'b0, 1'b0};
			RDA_IMM: tableCtrl = '{1'b1, 1'b0, 1'b0, 1'b0};
			UPA_RDB: tableCtrl = '{1'b1, 1'b1, 1'b1, 1'b0};
			UPA_IMM: tableCtrl = '{1'b1, 1'b1, 1'b0, 1'b0};
			RDB:     tableCtrl = '{1'b0, 1'b0, 1'b1, 1'b0};
			default: tableCtrl = '0;   // NONE and unknown codes
		endcase
	end

	// ##########################################################################
	// phase driven strobe registers
	// ##########################################################################

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			ctrl <= '0;
		end else begin
			case (phase)
				EXECUTE: begin
					// reads open for COMMIT and WRITEBACK
					ctrl.regAEn <= tableCtrl.regAEn;
					ctrl.regBEn <= tableCtrl.regBEn;
				end
				COMMIT: begin
					// writes open for WRITEBACK only
					ctrl.regAWen <= tableCtrl.regAWen;
					ctrl.regBWen <= tableCtrl.regBWen;
				end
				WRITEBACK: begin
					ctrl <= ctrl;   // held one cycle into IDLE
				end
				default: begin
					ctrl <= '0;     // IDLE, STOPPED, FETCH, DECODE
				end
			endcase
		end
	end

	// a write strobe opens only after its read strobe has been up a cycle
	assert property (@(posedge CLK) disable iff (RESET)
		$rose(ctrl.regAWen) |-> ctrl.regAEn && $past(ctrl.regAEn))
		else $error("regAWen rose without regAEn");

	assert property (@(posedge CLK) disable iff (RESET)
		$rose(ctrl.regBWen) |-> ctrl.regBEn && $past(ctrl.regBEn))
		else $error("regBWen rose without regBEn");

endmodule

/* tests/regStageModel.svh */
`ifndef REG_STAGE_MODEL_SVH
`define REG_STAGE_MODEL_SVH

// ##########################################################################
// reference model
// ##########################################################################

// one instruction applied to the model array, fields taken from the ISA layout
function automatic void applyInstr(input logic [15:0] word);
	logic [3:0]            code;
	logic                  byteX;
	int                    a;
	int                    b;
	logic [DATA_WIDTH-1:0] opA;
	logic [DATA_WIDTH-1:0] opB;
	logic [DATA_WIDTH-1:0] immX;
	logic [DATA_WIDTH-1:0] resA;
	logic                  wrA;
	logic                  wrB;
	code  = word[15:12];
	byteX = word[11];
	a     = word[10:8] % REG_COUNT;
	b     = word[7:5] % REG_COUNT;   // meaningless for immediate forms, never written then
	immX  = DATA_WIDTH'(word[7:0]);   // zero extended
	opA   = model[a];
	opB   = model[b];
	case (code)
		4'd2, 4'd3: resA = opB;         // LDA_RDB, LDA_UPB
		4'd5:       resA = immX;        // LDA_IMM
		4'd7:       resA = opA + opB;   // UPA_RDB
		4'd8:       resA = opA + immX;  // UPA_IMM
		default:    resA = opA;
	endcase
	wrA = code inside {4'd2, 4'd3, 4'd5, 4'd7, 4'd8};
	wrB = code inside {4'd3, 4'd4};     // stack step forms
	if (byteX) begin
		resA = {opA[DATA_WIDTH-1:8], resA[7:0]};   // high byte kept
	end
	if (wrA) begin
		model[a] = resA;
	end
	if (wrB) begin
		model[b] = opB - (byteX ? DATA_WIDTH'(1) : DATA_WIDTH'(2));   // B last, wins a clash
	end
endfunction

// ##########################################################################
// random source
// ##########################################################################

// 32 bit fibonacci, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// n fresh bits, one step per bit
function automatic logic [31:0] randBits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsrState = lfsrNext(lfsrState);
		v = {v[30:0], lfsrState[0]};
	end
	return v;
endfunction

// register value check
task automatic compareReg(input string name, input logic [DATA_WIDTH-1:0] expVal,
		input logic [DATA_WIDTH-1:0] actVal);
	if (actVal !== expVal) begin
		errCount++;
		$display("Fail %s expected %h actual %h", name, expVal, actVal);
	end
endtask

// response status check, pready and pslverr only
task automatic compareStatus(input string name, input apbRsp expRsp, input apbRsp actRsp);
	if (actRsp.pready !== expRsp.pready || actRsp.pslverr !== expRsp.pslverr) begin
		errCount++;
		$display("Fail %s expected pready %b pslverr %b actual pready %b pslverr %b",
			name, expRsp.pready, expRsp.pslverr, actRsp.pready, actRsp.pslverr);
	end
endtask

`endif

/* tests/regStageTb.sv */
`timescale 1ns/1ps

module regStageTb;
	import regBusPkg::*;

	localparam int DATA_WIDTH   = 16;
	localparam int REG_COUNT    = 8;
	localparam int SEED_COUNT   = REG_COUNT;   // one LDA_IMM per register
	localparam int RANDOM_COUNT = 24;
	localparam int BYTE_COUNT   = 8;
	localparam int STALL_ROUNDS = 2;
	localparam int HALT_ROUNDS  = 2;
	localparam int ERR_COUNT    = 6;
	// each checked instruction is followed by a NONE drain
	localparam int INSTR_COUNT  = 2 * (SEED_COUNT + RANDOM_COUNT + BYTE_COUNT)
		+ 3 * STALL_ROUNDS + 2 * HALT_ROUNDS;
	localparam int READ_COUNT   = ERR_COUNT + REG_COUNT * (2 + SEED_COUNT + RANDOM_COUNT
		+ BYTE_COUNT + STALL_ROUNDS + 2 * HALT_ROUNDS);
	localparam int CYCLE_LIMIT  = INSTR_COUNT * 12 + READ_COUNT * 4 + HALT_ROUNDS * 20 + 200;

	logic                  CLK;
	logic                  RESET;
	apbReq                 apbIn;
	apbRsp                 apbOut;
	logic                  halt;
	logic [DATA_WIDTH-1:0] model [REG_COUNT];   // expected register contents
	logic [31:0]           lfsrState;
	int                    errCount;
	int                    faultCount;
	int                    cycles;
	logic                  inAccess;   // host parked in an access phase
	apbRsp                 lastRsp;
	int                    lastWaits;  // cycles pready stayed low

	`include "regStageModel.svh"

	regStageTop #(.DATA_WIDTH(DATA_WIDTH), .REG_COUNT(REG_COUNT)) dut (
		.CLK    (CLK),
		.RESET  (RESET),
		.apbIn  (apbIn),
		.apbOut (apbOut),
		.halt   (halt)
	);

	always #2 CLK = ~CLK;   // 4 ns period

	// ##########################################################################
	// host side
	// ##########################################################################

	// one APB transfer, response sampled mid cycle during access
	task automatic apbTransfer(input logic write, input logic [7:0] addr,
			input logic [15:0] data);
		@(posedge CLK);
		apbIn.psel    <= 1'b1;   // setup
		apbIn.penable <= 1'b0;
		apbIn.pwrite  <= write;
		apbIn.paddr   <= addr;
		apbIn.pwdata  <= data;
		@(posedge CLK);
		apbIn.penable <= 1'b1;
		inAccess  = 1'b1;
		lastWaits = 0;
		@(negedge CLK);
		while (!apbOut.pready) begin
			lastWaits++;
			@(negedge CLK);
		end
		lastRsp = apbOut;
		@(posedge CLK);          // completing edge
		apbIn.psel    <= 1'b0;
		apbIn.penable <= 1'b0;
		inAccess = 1'b0;
	endtask

	task automatic sendInstr(input string name, input logic [15:0] word);
		apbRsp okRsp;
		okRsp = '{pready: 1'b1, pslverr: 1'b0, prdata: '0};
		apbTransfer(1'b1, 8'h00, word);
		compareStatus(name, okRsp, lastRsp);
	endtask

	// NONE write, completes once the previous instruction has written back
	task automatic drain(input string name);
		sendInstr({name, " drain"}, 16'h0000);
	endtask

	task automatic checkAllRegs(input string name);
		apbRsp okRsp;
		okRsp = '{pready: 1'b1, pslverr: 1'b0, prdata: '0};
		for (int i = 0; i < REG_COUNT; i++) begin
			apbTransfer(1'b0, 8'h10 + 8'(2 * i), 16'h0000);
			compareStatus($sformatf("%s r%0d status", name, i), okRsp, lastRsp);
			compareReg($sformatf("%s r%0d", name, i), model[i], lastRsp.prdata);
		end
	endtask

	task automatic runInstr(input string name, input logic [15:0] word);
		sendInstr(name, word);
		applyInstr(word);
		drain(name);
		checkAllRegs(name);
	endtask

	// ##########################################################################
	// test sequence
	// ##########################################################################

	initial begin
		logic [15:0] word;
		logic [15:0] second;
		logic [3:0]  byteCodes [6];   // codes that write something
		logic [7:0]  errAddr [ERR_COUNT];
		logic        errWrite [ERR_COUNT];
		apbRsp       errRsp;
		int          hold;
		CLK        = 1'b0;
		RESET      = 1'b1;
		apbIn      = '0;
		halt       = 1'b0;
		inAccess   = 1'b0;
		errCount   = 0;
		faultCount = 0;
		lastWaits  = 0;
		lfsrState  = 32'h31c83663;
		byteCodes  = '{4'd2, 4'd3, 4'd4, 4'd5, 4'd7, 4'd8};
		errAddr    = '{8'h00, 8'h04, 8'h12, 8'h20, 8'h13, 8'h40};
		errWrite   = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
		errRsp     = '{pready: 1'b1, pslverr: 1'b1, prdata: '0};
		for (int i = 0; i < REG_COUNT; i++) begin
			model[i] = '0;
		end
		repeat (5) @(posedge CLK);
		RESET <= 1'b0;

		checkAllRegs("reset");
		for (int i = 0; i < SEED_COUNT; i++) begin
			runInstr($sformatf("seed%0d", i), {4'd5, 1'b0, 3'(i), 8'(randBits(8))});
		end
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			word     = 16'(randBits(16));   // unknown codes included
			word[11] = 1'b0;               // word mode
			runInstr($sformatf("random%0d %h", i, word), word);
		end
		for (int i = 0; i < BYTE_COUNT; i++) begin
			word = {byteCodes[randBits(3) % 6], 1'b1, 11'(randBits(11))};
			runInstr($sformatf("byte%0d %h", i, word), word);
		end

		// back to back, second one parks in access until writeback is done
		for (int r = 0; r < STALL_ROUNDS; r++) begin
			word   = {4'd7, 1'b0, 11'(randBits(11))};
			second = {4'd3, 1'b0, 11'(randBits(11))};
			sendInstr($sformatf("stall%0d first", r), word);
			sendInstr($sformatf("stall%0d second", r), second);
			if (lastWaits != 3) begin
				faultCount++;
				$display("stall round %0d: second instruction waited %0d cycles instead of 3",
					r, lastWaits);
			end
			applyInstr(word);
			applyInstr(second);
			drain($sformatf("stall%0d", r));
			checkAllRegs($sformatf("stall%0d", r));
		end

		for (int r = 0; r < HALT_ROUNDS; r++) begin
			word = {byteCodes[randBits(3) % 6], 1'b0, 11'(randBits(11))};
			hold = 2 + int'(randBits(4));
			@(posedge CLK);
			halt <= 1'b1;
			sendInstr($sformatf("halt%0d", r), word);
			repeat (hold) @(posedge CLK);
			checkAllRegs($sformatf("halt%0d held", r));   // model not stepped yet
			@(posedge CLK);
			halt <= 1'b0;
			applyInstr(word);
			drain($sformatf("halt%0d", r));
			checkAllRegs($sformatf("halt%0d released", r));
		end

		for (int i = 0; i < ERR_COUNT; i++) begin
			apbTransfer(errWrite[i], errAddr[i], 16'(randBits(16)));
			compareStatus($sformatf("error access %h", errAddr[i]), errRsp, lastRsp);
		end
		checkAllRegs("after errors");

		$display("errors: %0d mismatches, %0d other faults", errCount, faultCount);
		if (errCount == 0 && faultCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// cycle limit
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge CLK);
			cycles++;
		end
		faultCount++;
		if (inAccess) begin
			$display("pready stayed low until the limit of %0d cycles", CYCLE_LIMIT);
		end else begin
			$display("the run did not finish within %0d cycles", CYCLE_LIMIT);
		end
		$display("errors: %0d mismatches, %0d other faults", errCount, faultCount);
		$display("=== FAIL ===");
		$finish;
	end

endmodule
